//--- source/obi_pkg.sv
/*
 * OBI bus definitions
 * Widths, the data word type and the bus opcode shared by bridge and testbench
 */

package obi_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_word_t;

  // Opcode derived from we, carried through the response stage
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

endpackage : obi_pkg

//--- source/ao_periph_pkg.sv
/*
 * Always-on peripheral map
 * Address windows, peripheral index, register offsets and interrupt widths
 */

package ao_periph_pkg;

  // Address map
  localparam obi_pkg::addr_t AO_BASE       = 32'h2000_0000;
  localparam obi_pkg::addr_t PERIPH_SPAN   = 32'h0000_1000;
  localparam int unsigned    AO_NUM_PERIPH = 3;

  // Window number after AO_BASE
  typedef enum logic [1:0] {
    PERIPH_SOC_CTRL  = 2'd0,
    PERIPH_TIMER     = 2'd1,
    PERIPH_FAST_INTR = 2'd2,
    PERIPH_NONE      = 2'd3
  } periph_idx_e;

  // Offset inside a 4 KiB window
  localparam int unsigned REG_OFF_W = 12;
  typedef logic [REG_OFF_W-1:0] reg_off_t;

  // SoC control registers
  localparam reg_off_t SOC_EXIT_VALID = 12'h000;
  localparam reg_off_t SOC_EXIT_VALUE = 12'h004;
  localparam reg_off_t SOC_BOOT_SEL   = 12'h008;
  localparam reg_off_t SOC_SCRATCH    = 12'h00C;

  // Timer registers, CTRL bit 0 and bit 1 enable the compares
  localparam reg_off_t TMR_MTIME = 12'h000;
  localparam reg_off_t TMR_CMP0  = 12'h004;
  localparam reg_off_t TMR_CMP1  = 12'h008;
  localparam reg_off_t TMR_CTRL  = 12'h00C;

  // Fast interrupt controller registers
  localparam reg_off_t FIC_PENDING = 12'h000;
  localparam reg_off_t FIC_ENABLE  = 12'h004;

  localparam int unsigned FAST_INTR_W = 15;
  typedef logic [FAST_INTR_W-1:0] fast_intr_t;

endpackage : ao_periph_pkg

//--- source/obi_reg_bridge.sv
/*
 * OBI to register bridge
 * Grants requests, decodes the peripheral window and returns read data a cycle later
 */

`timescale 1ns/10ps

module obi_reg_bridge (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     req_i,
  input  logic                     we_i,
  input  obi_pkg::addr_t           addr_i,
  input  obi_pkg::data_word_t      wdata_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output obi_pkg::data_word_t      rdata_o,

  output logic                     soc_we_o,
  output logic                     tmr_we_o,
  output logic                     fic_we_o,
  output ao_periph_pkg::reg_off_t  reg_off_o,
  output obi_pkg::data_word_t      reg_wdata_o,
  input  obi_pkg::data_word_t      soc_rdata_i,
  input  obi_pkg::data_word_t      tmr_rdata_i,
  input  obi_pkg::data_word_t      fic_rdata_i
);

  import obi_pkg::*;
  import ao_periph_pkg::*;

  logic        ready_q;
  logic        accept;
  bus_op_e     op;
  bus_op_e     op_q;
  addr_t       win_off;
  periph_idx_e sel;
  data_word_t  sel_rdata;
  data_word_t  rdata_q;
  logic        rvalid_q;

  // Grant opens one cycle after reset is released
  assign gnt_o  = req_i & ready_q;
  assign accept = req_i & gnt_o;
  assign op     = we_i ? OP_WRITE : OP_READ;

  // Addresses below AO_BASE wrap to a large offset and fall outside
  assign win_off = addr_i - AO_BASE;

  always_comb begin
    if (win_off < addr_t'(AO_NUM_PERIPH) * PERIPH_SPAN) begin
      sel = periph_idx_e'(win_off[REG_OFF_W +: 2]);
    end else begin
      sel = PERIPH_NONE;
    end
  end

  always_comb begin
    case (sel)
      PERIPH_SOC_CTRL:  sel_rdata = soc_rdata_i;
      PERIPH_TIMER:     sel_rdata = tmr_rdata_i;
      PERIPH_FAST_INTR: sel_rdata = fic_rdata_i;
      default:          sel_rdata = '0;
    endcase
  end

  assign soc_we_o    = accept && op == OP_WRITE && sel == PERIPH_SOC_CTRL;
  assign tmr_we_o    = accept && op == OP_WRITE && sel == PERIPH_TIMER;
  assign fic_we_o    = accept && op == OP_WRITE && sel == PERIPH_FAST_INTR;
  assign reg_off_o   = addr_i[REG_OFF_W-1:0];
  assign reg_wdata_o = wdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q  <= 1'b0;
      rvalid_q <= 1'b0;
      op_q     <= OP_WRITE;
    end else begin
      ready_q  <= 1'b1;
      rvalid_q <= accept;
      if (accept) begin
        op_q <= op;
      end
    end
  end

  // Response data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= sel_rdata;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = (op_q == OP_READ) ? rdata_q : '0;

endmodule : obi_reg_bridge

//--- source/soc_ctrl.sv
/*
 * SoC control block
 * Exit status, scratch word and readable boot select
 */

`timescale 1ns/10ps

module soc_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     reg_we_i,
  input  ao_periph_pkg::reg_off_t  reg_off_i,
  input  obi_pkg::data_word_t      reg_wdata_i,
  output obi_pkg::data_word_t      reg_rdata_o,

  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output obi_pkg::data_word_t      exit_value_o
);

  import obi_pkg::*;
  import ao_periph_pkg::*;

  logic       exit_valid_q;
  data_word_t exit_value_q;
  data_word_t scratch_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (reg_we_i) begin
      case (reg_off_i)
        SOC_EXIT_VALID: exit_valid_q <= reg_wdata_i[0];
        SOC_EXIT_VALUE: exit_value_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Scratch word
  always_ff @(posedge clk_i) begin
    if (reg_we_i && reg_off_i == SOC_SCRATCH) begin
      scratch_q <= reg_wdata_i;
    end
  end

  // Boot select is read only
  always_comb begin
    case (reg_off_i)
      SOC_EXIT_VALID: reg_rdata_o = {{(DATA_W-1){1'b0}}, exit_valid_q};
      SOC_EXIT_VALUE: reg_rdata_o = exit_value_q;
      SOC_BOOT_SEL:   reg_rdata_o = {{(DATA_W-1){1'b0}}, boot_select_i};
      SOC_SCRATCH:    reg_rdata_o = scratch_q;
      default:        reg_rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

//--- source/aon_timer.sv
/*
 * Always-on timer
 * Free-running mtime with two enabled compares driving two interrupts
 */

`timescale 1ns/10ps

module aon_timer (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     reg_we_i,
  input  ao_periph_pkg::reg_off_t  reg_off_i,
  input  obi_pkg::data_word_t      reg_wdata_i,
  output obi_pkg::data_word_t      reg_rdata_o,

  output logic                     timer_0_intr_o,
  output logic                     timer_1_intr_o
);

  import obi_pkg::*;
  import ao_periph_pkg::*;

  data_word_t mtime_q;
  data_word_t cmp0_q;
  data_word_t cmp1_q;
  logic [1:0] ctrl_q;
  logic       intr0_q;
  logic       intr1_q;

  // A write to mtime replaces the increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else if (reg_we_i && reg_off_i == TMR_MTIME) begin
      mtime_q <= reg_wdata_i;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q <= '0;
    end else if (reg_we_i && reg_off_i == TMR_CTRL) begin
      ctrl_q <= reg_wdata_i[1:0];
    end
  end

  // Compare values
  always_ff @(posedge clk_i) begin
    if (reg_we_i) begin
      case (reg_off_i)
        TMR_CMP0: cmp0_q <= reg_wdata_i;
        TMR_CMP1: cmp1_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr0_q <= 1'b0;
      intr1_q <= 1'b0;
    end else begin
      intr0_q <= ctrl_q[0] && (mtime_q >= cmp0_q);
      intr1_q <= ctrl_q[1] && (mtime_q >= cmp1_q);
    end
  end

  always_comb begin
    case (reg_off_i)
      TMR_MTIME: reg_rdata_o = mtime_q;
      TMR_CMP0:  reg_rdata_o = cmp0_q;
      TMR_CMP1:  reg_rdata_o = cmp1_q;
      TMR_CTRL:  reg_rdata_o = {{(DATA_W-2){1'b0}}, ctrl_q};
      default:   reg_rdata_o = '0;
    endcase
  end

  assign timer_0_intr_o = intr0_q;
  assign timer_1_intr_o = intr1_q;

endmodule : aon_timer

//--- source/fast_intr_ctrl.sv
/*
 * Fast interrupt controller
 * Pending capture with write-one-to-clear, gated by an enable mask
 */

`timescale 1ns/10ps

module fast_intr_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       reg_we_i,
  input  ao_periph_pkg::reg_off_t    reg_off_i,
  input  obi_pkg::data_word_t        reg_wdata_i,
  output obi_pkg::data_word_t        reg_rdata_o,

  input  ao_periph_pkg::fast_intr_t  fast_intr_i,
  output ao_periph_pkg::fast_intr_t  fast_intr_o
);

  import obi_pkg::*;
  import ao_periph_pkg::*;

  fast_intr_t pending_q;
  fast_intr_t enable_q;
  fast_intr_t intr_q;
  fast_intr_t clear;

  assign clear = (reg_we_i && reg_off_i == FIC_PENDING) ?
                 reg_wdata_i[FAST_INTR_W-1:0] : '0;

  // Set wins over clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear) | fast_intr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= '0;
    end else if (reg_we_i && reg_off_i == FIC_ENABLE) begin
      enable_q <= reg_wdata_i[FAST_INTR_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= pending_q & enable_q;
    end
  end

  always_comb begin
    case (reg_off_i)
      FIC_PENDING: reg_rdata_o = {{(DATA_W-FAST_INTR_W){1'b0}}, pending_q};
      FIC_ENABLE:  reg_rdata_o = {{(DATA_W-FAST_INTR_W){1'b0}}, enable_q};
      default:     reg_rdata_o = '0;
    endcase
  end

  assign fast_intr_o = intr_q;

endmodule : fast_intr_ctrl

//--- source/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem
 * OBI slave port bridged to SoC control, timer and fast interrupt controller
 */

`timescale 1ns/10ps

module ao_peripheral_subsystem (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       req_i,
  input  logic                       we_i,
  input  obi_pkg::addr_t             addr_i,
  input  obi_pkg::data_word_t        wdata_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output obi_pkg::data_word_t        rdata_o,

  input  logic                       boot_select_i,
  output logic                       exit_valid_o,
  output obi_pkg::data_word_t        exit_value_o,

  output logic                       rv_timer_0_intr_o,
  output logic                       rv_timer_1_intr_o,

  input  ao_periph_pkg::fast_intr_t  fast_intr_i,
  output ao_periph_pkg::fast_intr_t  fast_intr_o
);

  import obi_pkg::*;
  import ao_periph_pkg::*;

  logic       soc_we;
  logic       tmr_we;
  logic       fic_we;
  reg_off_t   reg_off;
  data_word_t reg_wdata;
  data_word_t soc_rdata;
  data_word_t tmr_rdata;
  data_word_t fic_rdata;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i, .reset_i,
    .req_i, .we_i, .addr_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o,
    .soc_we_o(soc_we), .tmr_we_o(tmr_we), .fic_we_o(fic_we),
    .reg_off_o(reg_off), .reg_wdata_o(reg_wdata),
    .soc_rdata_i(soc_rdata), .tmr_rdata_i(tmr_rdata), .fic_rdata_i(fic_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i, .reset_i,
    .reg_we_i(soc_we), .reg_off_i(reg_off), .reg_wdata_i(reg_wdata),
    .reg_rdata_o(soc_rdata),
    .boot_select_i, .exit_valid_o, .exit_value_o
  );

  aon_timer aon_timer_i (
    .clk_i, .reset_i,
    .reg_we_i(tmr_we), .reg_off_i(reg_off), .reg_wdata_i(reg_wdata),
    .reg_rdata_o(tmr_rdata),
    .timer_0_intr_o(rv_timer_0_intr_o),
    .timer_1_intr_o(rv_timer_1_intr_o)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i, .reset_i,
    .reg_we_i(fic_we), .reg_off_i(reg_off), .reg_wdata_i(reg_wdata),
    .reg_rdata_o(fic_rdata),
    .fast_intr_i, .fast_intr_o
  );

endmodule : ao_peripheral_subsystem

//--- testbench/ao_peripheral_subsystem_chk.sv
/*
 * Bound assertions for the always-on peripheral subsystem
 * Bus response timing, grant rule and reset state of the outputs
 */

`timescale 1ns/10ps

module ao_peripheral_subsystem_chk (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       req_i,
  input logic                       gnt_o,
  input logic                       rvalid_o,
  input logic                       exit_valid_o,
  input ao_periph_pkg::fast_intr_t  fast_intr_o
);

  // One response exactly one cycle after every accept
  assert property (@(posedge clk_i) disable iff (reset_i) (req_i && gnt_o) |=> rvalid_o)
    else $error("rvalid_o missing in the cycle after an accepted request");
  assert property (@(posedge clk_i) disable iff (reset_i) !(req_i && gnt_o) |=> !rvalid_o)
    else $error("rvalid_o high without an accepted request");

  // A request held through reset gets no grant yet
  assert property (@(posedge clk_i) reset_i |=> !gnt_o)
    else $error("gnt_o high in the first cycle after reset");

  assert property (@(posedge clk_i) reset_i |=> (!exit_valid_o && fast_intr_o == '0))
    else $error("exit_valid_o or fast_intr_o not cleared by reset");

endmodule : ao_peripheral_subsystem_chk

bind ao_peripheral_subsystem ao_peripheral_subsystem_chk ao_peripheral_subsystem_chk_i (.*);

//--- testbench/tb_ao_peripheral_subsystem.sv
/*
 * Testbench for the always-on peripheral subsystem
 * Table of OBI accesses with checks on read data and sideband outputs
 */

`timescale 1ns/10ps

module tb_ao_peripheral_subsystem;

  import obi_pkg::*;
  import ao_periph_pkg::*;

  localparam int    N_ENTRIES = 27;
  localparam int    TIMEOUT   = 16 + 4 * N_ENTRIES + 200;
  localparam addr_t SOC       = AO_BASE;
  localparam addr_t TMR       = AO_BASE + PERIPH_SPAN;
  localparam addr_t FIC       = AO_BASE + 2 * PERIPH_SPAN;
  localparam addr_t UNMAPPED  = AO_BASE + 3 * PERIPH_SPAN + 32'hC;

  logic        clk_i = 1'b0;
  logic        reset_i, req_i, we_i, boot_select_i, gnt_o, rvalid_o;
  logic        exit_valid_o, rv_timer_0_intr_o, rv_timer_1_intr_o;
  addr_t       addr_i;
  data_word_t  wdata_i, rdata_o, exit_value_o;
  fast_intr_t  fast_intr_i, fast_intr_o;

  // Stimulus table
  string       t_name  [N_ENTRIES];
  bus_op_e     t_op    [N_ENTRIES];
  addr_t       t_addr  [N_ENTRIES];
  data_word_t  t_wdata [N_ENTRIES];
  data_word_t  t_exp   [N_ENTRIES];
  bit          t_chk   [N_ENTRIES];
  data_word_t  resp    [N_ENTRIES];
  int          n_entries = 0;
  int          n_pass = 0;
  int          n_err = 0;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'd65842;

  ao_peripheral_subsystem ao_peripheral_subsystem_i (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic data_word_t lfsr_bits(input int n);
    data_word_t val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val = {val[DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  task automatic add_entry(input string name, input bus_op_e op, input addr_t a,
                           input data_word_t wd, input data_word_t exp, input bit chk);
    t_name[n_entries]  = name;
    t_op[n_entries]    = op;
    t_addr[n_entries]  = a;
    t_wdata[n_entries] = wd;
    t_exp[n_entries]   = exp;
    t_chk[n_entries]   = chk;
    n_entries++;
  endtask

  task automatic report_result(input string name, input bit ok, input data_word_t exp,
                               input data_word_t act);
    if (ok) begin
      n_pass++;
      $display("PASS  %s", name);
    end else begin
      n_err++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
    report_result(name, act === exp, exp, act);
  endtask

  task automatic check_intr(input string name, input fast_intr_t exp, input fast_intr_t act);
    report_result(name, act === exp, data_word_t'(exp), data_word_t'(act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    report_result(name, act === exp, data_word_t'(exp), data_word_t'(act));
  endtask

  task automatic collect_response(input int i);
    resp[i] = rdata_o;
    if (rvalid_o !== 1'b1) begin
      n_err++;
      $display("FAIL  %s got no response in the cycle after its grant", t_name[i]);
    end else if (t_chk[i]) begin
      check_word(t_name[i], t_exp[i], rdata_o);
    end else begin
      $display("DONE  %s read %h", t_name[i], rdata_o);
    end
  endtask

  task automatic run_entries(input int first, input int last, input bit burst);
    for (int i = first; i <= last; i++) begin
      @(posedge clk_i);
      req_i   <= 1'b1;
      we_i    <= (t_op[i] == OP_WRITE);
      addr_i  <= t_addr[i];
      wdata_i <= t_wdata[i];
      @(negedge clk_i);
      if (gnt_o !== 1'b1) begin
        n_err++;
        $display("FAIL  %s was not granted", t_name[i]);
      end
      // In a burst the previous response shows up next to this grant
      if (burst && i > first) begin
        collect_response(i - 1);
      end
      if (!burst || i == last) begin
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
        collect_response(i);
      end
    end
  endtask

  initial begin
    data_word_t rnd_scratch;
    data_word_t rnd_exit;
    data_word_t rnd_late;
    fast_intr_t pat;
    fast_intr_t clr;
    fast_intr_t en;
    int         waited;
    reset_i       = 1'b1;
    // Request held through reset must not be granted
    req_i         = 1'b1;
    we_i          = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    boot_select_i = 1'b1;
    fast_intr_i   = '0;
    rnd_scratch   = lfsr_bits(32);
    rnd_exit      = lfsr_bits(32);
    rnd_late      = lfsr_bits(32);
    pat           = fast_intr_t'(lfsr_bits(FAST_INTR_W)) | 15'h0011;
    clr           = pat & 15'h000F;
    en            = 15'h0F0F;
    waited        = 0;

    add_entry("rd_exit_valid_rst", OP_READ, SOC + SOC_EXIT_VALID, '0, '0, 1'b1);
    add_entry("rd_tmr_ctrl_rst", OP_READ, TMR + TMR_CTRL, '0, '0, 1'b1);
    add_entry("rd_fic_pending_rst", OP_READ, FIC + FIC_PENDING, '0, '0, 1'b1);
    add_entry("rd_fic_enable_rst", OP_READ, FIC + FIC_ENABLE, '0, '0, 1'b1);
    // SoC control, entries 4 to 9
    add_entry("wr_scratch", OP_WRITE, SOC + SOC_SCRATCH, rnd_scratch, '0, 1'b1);
    add_entry("wr_exit_value", OP_WRITE, SOC + SOC_EXIT_VALUE, rnd_exit, '0, 1'b1);
    add_entry("rd_scratch", OP_READ, SOC + SOC_SCRATCH, '0, rnd_scratch, 1'b1);
    add_entry("rd_exit_value", OP_READ, SOC + SOC_EXIT_VALUE, '0, rnd_exit, 1'b1);
    add_entry("wr_exit_valid", OP_WRITE, SOC + SOC_EXIT_VALID, 32'd1, '0, 1'b1);
    add_entry("rd_boot_sel", OP_READ, SOC + SOC_BOOT_SEL, '0, 32'd1, 1'b1);
    // Timer, entries 10 to 15
    add_entry("wr_cmp0", OP_WRITE, TMR + TMR_CMP0, '0, '0, 1'b1);
    add_entry("wr_cmp1", OP_WRITE, TMR + TMR_CMP1, 32'hFFFF_FFF0, '0, 1'b1);
    add_entry("wr_tmr_ctrl", OP_WRITE, TMR + TMR_CTRL, 32'd3, '0, 1'b1);
    add_entry("rd_mtime_first", OP_READ, TMR + TMR_MTIME, '0, '0, 1'b0);
    add_entry("rd_mtime_second", OP_READ, TMR + TMR_MTIME, '0, '0, 1'b0);
    add_entry("wr_mtime", OP_WRITE, TMR + TMR_MTIME, 32'hFFFF_FFF8, '0, 1'b1);
    // Fast interrupts, entries 16 to 19
    add_entry("wr_fic_enable", OP_WRITE, FIC + FIC_ENABLE, data_word_t'(en), '0, 1'b1);
    add_entry("rd_fic_pending", OP_READ, FIC + FIC_PENDING, '0, data_word_t'(pat), 1'b1);
    add_entry("wr_fic_clear", OP_WRITE, FIC + FIC_PENDING, data_word_t'(clr), '0, 1'b1);
    add_entry("rd_fic_cleared", OP_READ, FIC + FIC_PENDING, '0, data_word_t'(pat & ~clr), 1'b1);
    // Decode, then a back-to-back burst from entry 22
    add_entry("wr_unmapped", OP_WRITE, UNMAPPED, 32'hFFFF_FFFF, '0, 1'b1);
    add_entry("rd_unmapped", OP_READ, UNMAPPED, '0, '0, 1'b1);
    add_entry("b2b_rd_scratch", OP_READ, SOC + SOC_SCRATCH, '0, rnd_scratch, 1'b1);
    add_entry("b2b_rd_fic_enable", OP_READ, FIC + FIC_ENABLE, '0, data_word_t'(en), 1'b1);
    add_entry("b2b_wr_scratch", OP_WRITE, SOC + SOC_SCRATCH, rnd_late, '0, 1'b1);
    add_entry("b2b_rd_scratch_new", OP_READ, SOC + SOC_SCRATCH, '0, rnd_late, 1'b1);
    add_entry("b2b_rd_boot_sel", OP_READ, SOC + SOC_BOOT_SEL, '0, '0, 1'b1);

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("gnt_after_reset", 1'b0, gnt_o);
    check_flag("exit_valid_after_reset", 1'b0, exit_valid_o);
    check_word("exit_value_after_reset", '0, exit_value_o);
    check_flag("timer_0_after_reset", 1'b0, rv_timer_0_intr_o);
    check_flag("timer_1_after_reset", 1'b0, rv_timer_1_intr_o);
    check_intr("fast_intr_after_reset", '0, fast_intr_o);

    run_entries(0, 9, 1'b0);
    check_word("exit_value_out", rnd_exit, exit_value_o);
    check_flag("exit_valid_out", 1'b1, exit_valid_o);

    run_entries(10, 14, 1'b0);
    check_flag("timer_0_intr_on", 1'b1, rv_timer_0_intr_o);
    check_flag("timer_1_intr_off", 1'b0, rv_timer_1_intr_o);
    check_flag("mtime_increasing", 1'b1, resp[14] > resp[13]);
    run_entries(15, 15, 1'b0);
    // mtime wraps 8 cycles after the load, so stop at the first high sample
    while (rv_timer_1_intr_o !== 1'b1 && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    check_flag("timer_1_intr_on", 1'b1, rv_timer_1_intr_o);

    run_entries(16, 16, 1'b0);
    @(posedge clk_i);
    fast_intr_i <= pat;
    @(posedge clk_i);
    fast_intr_i <= '0;
    run_entries(17, 17, 1'b0);
    check_intr("fast_intr_out", pat & en, fast_intr_o);
    run_entries(18, 19, 1'b0);
    check_intr("fast_intr_out_cleared", pat & ~clr & en, fast_intr_o);

    run_entries(20, 21, 1'b0);
    @(posedge clk_i);
    boot_select_i <= 1'b0;
    run_entries(22, 26, 1'b1);

    $display("Checks passed: %0d, errors: %0d", n_pass, n_err);
    if (n_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

//--- compile.f
source/obi_pkg.sv
source/ao_periph_pkg.sv
source/obi_reg_bridge.sv
source/soc_ctrl.sv
source/aon_timer.sv
source/fast_intr_ctrl.sv
source/ao_peripheral_subsystem.sv
testbench/ao_peripheral_subsystem_chk.sv
testbench/tb_ao_peripheral_subsystem.sv
